// ==== Makefile ====
# Verilator build and run of the cluster testbench.
TOP = tb_cluster

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): files.f $(wildcard *.sv *.svh)
	verilator --binary --timing -j 0 --top-module $(TOP) -f files.f -o V$(TOP)

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "^Test OK$$" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== cluster.sv ====
`timescale 1ns/1ps

`include "cluster_defines.svh"

module cluster (
    input  logic                   clk,
    input  logic                   reset,

    // Core memory ports.
    input  mem_pkg::mem_req_t      core_req [`NUM_CORES],
    output logic [`NUM_CORES-1:0]  core_req_credit,
    output mem_pkg::mem_rsp_t      core_rsp [`NUM_CORES],

    // ROP port.
    input  mem_pkg::mem_req_t      rop_req,
    output logic                   rop_req_credit,
    output mem_pkg::mem_rsp_t      rop_rsp,

    // External memory.
    output mem_pkg::mem_req_t      mem_req,
    input  logic                   mem_req_credit,
    input  mem_pkg::mem_rsp_t      mem_rsp,

    output logic                   busy
);
    localparam int NUM_OUT = cluster_pkg::NUM_OUT_PORTS;

    mem_pkg::mem_req_t   out_req [NUM_OUT];
    mem_pkg::mem_rsp_t   out_rsp [NUM_OUT];
    logic [NUM_OUT-1:0]  out_req_credit;
    logic                core_busy;
    logic                out_busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Core level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Downstream credits are the output mux queue slots.
    mem_mux #(
        .NUM_REQS    (`NUM_CORES),
        .IDX_BITS    ($bits(cluster_pkg::core_idx_t)),
        .OUT_CREDITS (`REQ_CREDITS)
    ) core_mux (
        .clk            (clk),
        .reset          (reset),
        .req_in         (core_req),
        .req_in_credit  (core_req_credit),
        .rsp_in         (core_rsp),
        .req_out        (out_req[cluster_pkg::PORT_CORES]),
        .req_out_credit (out_req_credit[cluster_pkg::PORT_CORES]),
        .rsp_out        (out_rsp[cluster_pkg::PORT_CORES]),
        .busy           (core_busy)
    );

    // ROP joins at the second level.
    assign out_req[cluster_pkg::PORT_ROP] = rop_req;
    assign rop_req_credit = out_req_credit[cluster_pkg::PORT_ROP];
    assign rop_rsp        = out_rsp[cluster_pkg::PORT_ROP];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_mux #(
        .NUM_REQS    (NUM_OUT),
        .IDX_BITS    ($bits(cluster_pkg::out_idx_t)),
        .OUT_CREDITS (`MEM_CREDITS)
    ) out_mux (
        .clk            (clk),
        .reset          (reset),
        .req_in         (out_req),
        .req_in_credit  (out_req_credit),
        .rsp_in         (out_rsp),
        .req_out        (mem_req),
        .req_out_credit (mem_req_credit),
        .rsp_out        (mem_rsp),
        .busy           (out_busy)
    );

    assign busy = core_busy | out_busy;

endmodule

// ==== cluster_defines.svh ====
`ifndef CLUSTER_DEFINES_SVH
`define CLUSTER_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cluster sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NUM_CORES   4       // Core memory ports.

// Mux input queue depth, also the sender's credit count after reset.
`define REQ_CREDITS 4

// Credits granted by the external memory.
`define MEM_CREDITS 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define ADDR_BITS   32
`define DATA_BITS   32

// Same width at every hop.
// Each mux level takes index bits from the top, 5 left for the source.
`define TAG_BITS    8

`endif

// ==== cluster_golden.txt ====
// port write address data source_tag expected_read_data
// Port 0-3 core, 4 ROP, e stall (data = cycles), f wait until idle.
0 1 00000100 a0a00001 01 00000000
1 1 00000104 b1b10002 02 00000000
2 1 00000108 c2c20003 03 00000000
3 1 0000010c d3d30004 04 00000000
4 1 00000110 e4e40005 05 00000000
0 0 00000100 00000000 06 a0a00001
1 0 00000104 00000000 07 b1b10002
2 0 00000108 00000000 08 c2c20003
3 0 0000010c 00000000 09 d3d30004
4 0 00000110 00000000 0a e4e40005
f 0 00000000 00000000 00 00000000
// Reads from other ports.
4 0 00000100 00000000 1f a0a00001
3 0 00000104 00000000 1e b1b10002
0 0 00000110 00000000 1d e4e40005
2 0 0000010c 00000000 1c d3d30004
1 0 00000108 00000000 1b c2c20003
f 0 00000000 00000000 00 00000000
// Memory holds answers and credits for 60 cycles.
e 0 00000000 0000003c 00 00000000
0 1 00000200 12340000 10 00000000
1 1 00000204 12340001 11 00000000
2 1 00000208 12340002 12 00000000
3 1 0000020c 12340003 13 00000000
4 1 00000210 12340004 14 00000000
0 0 00000200 00000000 15 12340000
1 0 00000204 00000000 16 12340001
2 0 00000208 00000000 17 12340002
3 0 0000020c 00000000 18 12340003
4 0 00000210 00000000 19 12340004
0 1 00000214 0badf00d 1a 00000000
0 0 00000214 00000000 1b 0badf00d
0 0 00000100 00000000 1c a0a00001
0 1 00000218 5555aaaa 0b 00000000
0 1 0000021c 3c3c3c3c 0c 00000000
0 0 00000218 00000000 0d 5555aaaa
0 0 0000021c 00000000 0e 3c3c3c3c
f 0 00000000 00000000 00 00000000

// ==== cluster_pkg.sv ====
`include "cluster_defines.svh"

package cluster_pkg;

    // Core level index.
    localparam int CORE_IDX_BITS = $clog2(`NUM_CORES);
    typedef logic [CORE_IDX_BITS-1:0] core_idx_t;

    // Output level, core traffic and ROP traffic.
    localparam int NUM_OUT_PORTS = 2;
    localparam int OUT_IDX_BITS  = $clog2(NUM_OUT_PORTS);
    typedef logic [OUT_IDX_BITS-1:0] out_idx_t;

    localparam out_idx_t PORT_CORES = out_idx_t'(0);
    localparam out_idx_t PORT_ROP   = out_idx_t'(1);

endpackage

// ==== files.f ====
+incdir+.
mem_pkg.sv
cluster_pkg.sv
mem_req_queue.sv
mem_mux.sv
cluster.sv
tb_cluster.sv

// ==== mem_mux.sv ====
`timescale 1ns/1ps

`include "cluster_defines.svh"

module mem_mux #(
    parameter int NUM_REQS    = 4,
    parameter int IDX_BITS    = 2,
    parameter int OUT_CREDITS = 4
) (
    input  logic              clk,
    input  logic              reset,

    // Input side.
    input  mem_pkg::mem_req_t req_in [NUM_REQS],
    output logic [NUM_REQS-1:0] req_in_credit,
    output mem_pkg::mem_rsp_t rsp_in [NUM_REQS],

    // Output side.
    output mem_pkg::mem_req_t req_out,
    input  logic              req_out_credit,
    input  mem_pkg::mem_rsp_t rsp_out,

    output logic              busy
);
    localparam int CREDIT_BITS = $clog2(OUT_CREDITS + 1);
    // Headroom for requests sitting in downstream queues and registers.
    localparam int OUTST_BITS  = $clog2(NUM_REQS * `REQ_CREDITS + OUT_CREDITS + 1) + 1;

    mem_pkg::mem_req_t        head [NUM_REQS];
    mem_pkg::mem_req_t        sel_req;
    logic [NUM_REQS-1:0]      empty;
    logic [NUM_REQS-1:0]      pop;
    logic [NUM_REQS-1:0]      rsp_valid;
    logic [IDX_BITS-1:0]      last_grant;
    logic [IDX_BITS-1:0]      grant_idx;
    logic [IDX_BITS-1:0]      rsp_sel;
    logic                     found;
    logic                     grant;
    logic [CREDIT_BITS-1:0]   credit_cnt;
    logic [OUTST_BITS-1:0]    outstanding;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Input queues
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_queue
        mem_req_queue u_queue (
            .clk        (clk),
            .reset      (reset),
            .req_in     (req_in[i]),
            .req_credit (req_in_credit[i]),
            .head       (head[i]),
            .pop        (pop[i]),
            .empty      (empty[i])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Round-robin arbitration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // First non-empty queue after the last grant.
    always_comb begin
        int cand;
        found     = 1'b0;
        grant_idx = '0;
        for (int k = 1; k <= NUM_REQS; k++) begin
            cand = (int'(last_grant) + k) % NUM_REQS;
            if (!found && !empty[cand]) begin
                found     = 1'b1;
                grant_idx = IDX_BITS'(cand);
            end
        end
    end

    assign grant   = found && (credit_cnt != '0);
    assign pop     = grant ? (NUM_REQS'(1) << grant_idx) : '0;
    assign sel_req = head[grant_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant  <= IDX_BITS'(NUM_REQS - 1);    // Start search at input 0.
            credit_cnt  <= CREDIT_BITS'(OUT_CREDITS);
            outstanding <= '0;
        end else begin
            if (grant) begin
                last_grant <= grant_idx;
            end
            credit_cnt  <= credit_cnt - CREDIT_BITS'(grant) + CREDIT_BITS'(req_out_credit);
            outstanding <= outstanding + OUTST_BITS'(grant) - OUTST_BITS'(rsp_out.valid);
        end
    end

    // Output register, source index goes into the low tag bits.
    always_ff @(posedge clk) begin
        if (reset) begin
            req_out.valid <= 1'b0;
        end else begin
            req_out.valid <= grant;
        end
        req_out.write <= sel_req.write;
        req_out.addr  <= sel_req.addr;
        req_out.data  <= sel_req.data;
        req_out.tag   <= {sel_req.tag[`TAG_BITS-IDX_BITS-1:0], grant_idx};
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign rsp_sel = rsp_out.tag[IDX_BITS-1:0];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_REQS; i++) begin
            if (reset) begin
                rsp_in[i].valid <= 1'b0;
            end else begin
                rsp_in[i].valid <= rsp_out.valid && (rsp_sel == IDX_BITS'(i));
            end
            rsp_in[i].data <= rsp_out.data;
            rsp_in[i].tag  <= rsp_out.tag >> IDX_BITS;   // Restore sender tag.
        end
    end

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_rsp_valid
        assign rsp_valid[i] = rsp_in[i].valid;
    end

    assign busy = !(&empty) || (outstanding != '0) || (|rsp_valid);

endmodule

// ==== mem_pkg.sv ====
`include "cluster_defines.svh"

package mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory request, 74 bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                  valid;
        logic                  write;   // Write when set.
        logic [`ADDR_BITS-1:0] addr;
        logic [`DATA_BITS-1:0] data;    // Write data.
        logic [`TAG_BITS-1:0]  tag;
    } mem_req_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory response, 41 bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Writes answer too, with zero data.
    typedef struct packed {
        logic                  valid;
        logic [`DATA_BITS-1:0] data;    // Read data.
        logic [`TAG_BITS-1:0]  tag;
    } mem_rsp_t;

endpackage

// ==== mem_req_queue.sv ====
`timescale 1ns/1ps

`include "cluster_defines.svh"

module mem_req_queue (
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::mem_req_t req_in,
    output logic              req_credit,
    output mem_pkg::mem_req_t head,
    input  logic              pop,
    output logic              empty
);
    localparam int DEPTH    = `REQ_CREDITS;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    mem_pkg::mem_req_t       slots [DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr;
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [CNT_BITS-1:0]     count;

    // Sender holds the credits, so a valid always has a free slot.
    always_ff @(posedge clk) begin
        if (req_in.valid) begin
            slots[wr_ptr] <= req_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_in.valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count      <= count + CNT_BITS'(req_in.valid) - CNT_BITS'(pop);
            req_credit <= pop;  // Slot goes back one cycle after pop.
        end
    end

    assign head  = slots[rd_ptr];
    assign empty = (count == '0);

endmodule

// ==== tb_cluster.sv ====
`timescale 1ns/1ps

`include "cluster_defines.svh"

module tb_cluster;
    localparam int NUM_PORTS = `NUM_CORES + 1;   // Cores first, ROP last.
    localparam int ROP_PORT  = `NUM_CORES;
    localparam int MAX_RECS  = 64;
    localparam int FIELDS    = 6;
    localparam int STALL     = 'he;
    localparam int BARRIER   = 'hf;

    logic                  clk = 1'b0;
    logic                  reset;
    mem_pkg::mem_req_t     core_req [`NUM_CORES];
    logic [`NUM_CORES-1:0] core_req_credit;
    mem_pkg::mem_rsp_t     core_rsp [`NUM_CORES];
    mem_pkg::mem_req_t     rop_req;
    logic                  rop_req_credit;
    mem_pkg::mem_rsp_t     rop_rsp;
    mem_pkg::mem_req_t     mem_req;
    logic                  mem_req_credit = 1'b0;
    mem_pkg::mem_rsp_t     mem_rsp = '0;
    logic                  busy;

    mem_pkg::mem_rsp_t     port_rsp [NUM_PORTS];
    logic [NUM_PORTS-1:0]  port_credit;
    logic [31:0]           golden [MAX_RECS*FIELDS];
    logic [31:0]           mem_words [256];
    mem_pkg::mem_rsp_t     pend_rsp [$];
    int                    pend_due [$];
    int pend_rec [NUM_PORTS][MAX_RECS];
    int used [NUM_PORTS] = '{default: 0};
    int returned [NUM_PORTS] = '{default: 0};
    int rsp_head [NUM_PORTS] = '{default: 0};
    int rsp_tail [NUM_PORTS] = '{default: 0};
    int sent_cnt [256] = '{default: 0};
    int seen_cnt [256] = '{default: 0};
    int num_recs = 0;
    int limit = 0;
    int cycle = 0;
    int stall_until = 0;
    int inflight = 0;
    int issued = 0;
    int rsp_total = 0;
    int n_checks = 0;
    int value_errors = 0;
    int other_errors = 0;

    always #50 clk = ~clk;

    cluster u_cluster (
        .clk             (clk),
        .reset           (reset),
        .core_req        (core_req),
        .core_req_credit (core_req_credit),
        .core_rsp        (core_rsp),
        .rop_req         (rop_req),
        .rop_req_credit  (rop_req_credit),
        .rop_rsp         (rop_rsp),
        .mem_req         (mem_req),
        .mem_req_credit  (mem_req_credit),
        .mem_rsp         (mem_rsp),
        .busy            (busy)
    );

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_port
        assign port_rsp[i] = core_rsp[i];
    end
    assign port_rsp[ROP_PORT] = rop_rsp;
    assign port_credit = {rop_req_credit, core_req_credit};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        n_checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // Tag expected on mem_req from the per-level tag rule.
    function automatic logic [`TAG_BITS-1:0] mem_tag(input int port,
                                                      input logic [`TAG_BITS-1:0] src);
        if (port == ROP_PORT)
            return {src[`TAG_BITS-2:0], 1'b1};
        return {src[`TAG_BITS-4:0], 2'(port), 1'b0};
    endfunction

    function automatic int credits_left(input int p);
        return `REQ_CREDITS - used[p] + returned[p];
    endfunction

    task automatic idle_ports();
        for (int p = 0; p < `NUM_CORES; p++)
            core_req[p] <= '0;
        rop_req <= '0;
    endtask

    task automatic send(input int r);
        mem_pkg::mem_req_t req;
        int b;
        int p;
        b = r * FIELDS;
        p = int'(golden[b]);
        req.valid = 1'b1;
        req.write = golden[b+1][0];
        req.addr  = golden[b+2];
        req.data  = golden[b+3];
        req.tag   = golden[b+4][`TAG_BITS-1:0];
        if (p == ROP_PORT)
            rop_req <= req;
        else
            core_req[p] <= req;
        used[p]++;
        pend_rec[p][rsp_tail[p]] = r;
        rsp_tail[p]++;
        sent_cnt[mem_tag(p, req.tag)]++;
        issued++;
    endtask

    task automatic drain();
        @(posedge clk);
        idle_ports();
        while (rsp_total != issued)
            @(posedge clk);
    endtask

    task automatic check_quiet();
        check_value(32'(mem_req.valid), 0, "mem_req valid after reset");
        for (int p = 0; p < NUM_PORTS; p++)
            check_value(32'(port_rsp[p].valid), 0, $sformatf("port %0d response valid", p));
        check_value(32'(port_credit), 0, "credit pulses after reset");
        check_value(32'(busy), 0, "busy after reset");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin : memory_model
        mem_pkg::mem_rsp_t answer;
        mem_pkg::mem_rsp_t accepted;
        logic [7:0]        idx;
        if (reset) begin
            for (int a = 0; a < 256; a++)
                mem_words[a] = 32'h6b00_0000 ^ (32'(a) * 32'h0001_0101);
            mem_rsp        <= '0;
            mem_req_credit <= 1'b0;
        end else begin
            answer = '0;
            mem_req_credit <= 1'b0;
            if (pend_rsp.size() > 0 && cycle >= pend_due[0] && cycle >= stall_until) begin
                answer = pend_rsp.pop_front();
                void'(pend_due.pop_front());
                mem_req_credit <= 1'b1;     // Credit goes back with the answer.
                inflight--;
            end
            mem_rsp <= answer;
            if (mem_req.valid) begin
                check_value(32'(inflight < `MEM_CREDITS), 1, "mem_req within memory credits");
                check_value(32'(seen_cnt[mem_req.tag] < sent_cnt[mem_req.tag]), 1,
                            $sformatf("mem_req tag %0h from an issued request", mem_req.tag));
                check_value(32'(busy), 1, "busy while a request is on mem_req");
                seen_cnt[mem_req.tag]++;
                idx = mem_req.addr[9:2];
                accepted.valid = 1'b1;
                accepted.tag   = mem_req.tag;
                if (mem_req.write) begin
                    mem_words[idx] = mem_req.data;
                    accepted.data  = '0;
                end else begin
                    accepted.data = mem_words[idx];
                end
                pend_rsp.push_back(accepted);
                pend_due.push_back(cycle + 3);
                inflight++;
            end
        end
    end

    // Per-port responses come back in issue order.
    always @(posedge clk) begin : response_monitor
        int r;
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (reset) begin
                returned[p] <= 0;
                rsp_head[p] <= 0;
            end else begin
                if (port_credit[p])
                    returned[p] <= returned[p] + 1;
                if (port_rsp[p].valid) begin
                    n++;
                    if (rsp_head[p] == rsp_tail[p]) begin
                        other_errors++;
                        $display("Port %0d returned a response with no request pending.", p);
                    end else begin
                        r = pend_rec[p][rsp_head[p]];
                        rsp_head[p] <= rsp_head[p] + 1;
                        check_value(32'(port_rsp[p].tag), golden[r*FIELDS+4],
                                    $sformatf("port %0d response tag", p));
                        check_value(port_rsp[p].data, golden[r*FIELDS+5],
                                    $sformatf("port %0d read data", p));
                    end
                end
            end
        end
        rsp_total <= rsp_total + n;
    end

    always @(posedge clk) begin : watchdog
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : stimulus
        int b;
        int p;
        for (int i = 0; i < MAX_RECS*FIELDS; i++)
            golden[i] = '1;
        $readmemh("cluster_golden.txt", golden);
        while (num_recs < MAX_RECS && golden[num_recs*FIELDS] != '1)
            num_recs++;
        limit = 40 * num_recs + 200;
        reset <= 1'b1;
        idle_ports();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        check_quiet();

        for (int r = 0; r < num_recs; r++) begin
            b = r * FIELDS;
            p = int'(golden[b]);
            if (p == BARRIER) begin
                drain();
            end else if (p == STALL) begin
                stall_until <= cycle + int'(golden[b+3]);
            end else begin
                while (credits_left(p) <= 0) begin   // Hold off until a credit returns.
                    @(posedge clk);
                    idle_ports();
                end
                @(posedge clk);
                idle_ports();
                send(r);
            end
        end
        drain();
        @(posedge clk);
        check_value(32'(busy), 0, "busy after the last response");
        check_value(32'(rsp_total), 32'(issued), "response count");

        $display("checks %0d, value errors %0d, other errors %0d",
                 n_checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
